// File: verilog/sched_pkg.sv
// issue scheduler package with window sizes, index types and the interface structs
package sched_pkg;

	// ========================================
	// sizes
	// ========================================

	// capacity of the reorder window in entries
	localparam int ROB_ENTRIES = 16;
	// the selector only looks this far from the head
	localparam int WINDOW_SIZE = 8;
	// operations a single issue port may have outstanding
	localparam int UNIT_CREDITS = 2;
	localparam int TAG_W = 8;
	// two ALU ports and one flow-control port
	localparam int NUM_PORTS = 3;
	localparam int CREDIT_W = $clog2(UNIT_CREDITS + 1);

	// ========================================
	// basic types
	// ========================================

	typedef logic [$clog2(ROB_ENTRIES)-1:0] rob_ndx_t;
	typedef logic [ROB_ENTRIES-1:0] rob_bitmask_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	// ALU0_ONLY operations may only run on the first ALU
	typedef enum logic [1:0] {
		ALU = 2'd0,
		ALU0_ONLY = 2'd1,
		FC = 2'd2
	} op_class_e;

	typedef enum logic [1:0] {
		ALU0 = 2'd0,
		ALU1 = 2'd1,
		FCU = 2'd2
	} port_e;

	// ========================================
	// interface structs
	// ========================================

	typedef struct packed {
		logic v;
		op_class_e cls;
		tag_t tag;
	} dispatch_t;

	// issued and done track the life of the entry after dispatch
	typedef struct packed {
		logic v;
		op_class_e cls;
		tag_t tag;
		logic issued;
		logic done;
	} rob_entry_t;

	typedef struct packed {
		logic v;
		rob_ndx_t ndx;
		tag_t tag;
	} issue_t;

	// a unit names its own port so the right credit comes back
	typedef struct packed {
		logic v;
		port_e port;
		rob_ndx_t ndx;
	} complete_t;

	typedef struct packed {
		logic v;
		tag_t tag;
	} retire_t;

endpackage

// File: verilog/rob_window.sv
// reorder window holding dispatched operations until they retire in order from the head
`timescale 1ns/100ps

module rob_window (
	input logic clk,
	input logic rst,
	input sched_pkg::dispatch_t dispatch_i,
	input sched_pkg::issue_t alu0_issue_i,
	input sched_pkg::issue_t alu1_issue_i,
	input sched_pkg::issue_t fcu_issue_i,
	input sched_pkg::complete_t complete_i,
	output sched_pkg::rob_entry_t [sched_pkg::ROB_ENTRIES-1:0] rob_entries_o,
	output sched_pkg::rob_ndx_t head_o,
	output sched_pkg::retire_t retire_o,
	output logic dispatch_credit_o
);

	import sched_pkg::*;

	// ========================================
	// window state
	// ========================================

	// the entry array is a circular buffer between head and tail
	rob_entry_t [ROB_ENTRIES-1:0] rob_q;
	// head is the oldest live entry and tail is the next free slot
	rob_ndx_t head_q;
	rob_ndx_t tail_q;

	// the three grant buses gathered so one loop can mark them all
	issue_t [NUM_PORTS-1:0] grants;

	// high when the oldest entry has finished and can leave
	logic retire_go;

	assign grants = {fcu_issue_i, alu1_issue_i, alu0_issue_i};

	// an empty head slot has v low, so an empty window never retires
	assign retire_go = rob_q[head_q].v && rob_q[head_q].done;

	// ========================================
	// entry updates
	// ========================================

	// all updates land on one edge
	// the dispatcher cannot write the slot being retired in the same cycle,
	// because a full window leaves it without credits until the retire pulse
	// has gone out
	always_ff @(posedge clk) begin
		if (rst) begin
			// every slot starts empty with its status bits clear
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				rob_q[i].v <= 1'b0;
				rob_q[i].issued <= 1'b0;
				rob_q[i].done <= 1'b0;
			end
			head_q <= '0;
			tail_q <= '0;
			retire_o <= '0;
			dispatch_credit_o <= 1'b0;
		end else begin
			// retire at most one entry per cycle from the head
			retire_o <= '{v: retire_go, tag: rob_q[head_q].tag};
			// every retired entry hands one credit back to the dispatcher
			dispatch_credit_o <= retire_go;
			if (retire_go) begin
				rob_q[head_q].v <= 1'b0;
				head_q <= head_q + rob_ndx_t'(1);
			end

			// a new operation goes in at the tail with clean status
			if (dispatch_i.v) begin
				rob_q[tail_q] <= '{
					v: 1'b1,
					cls: dispatch_i.cls,
					tag: dispatch_i.tag,
					issued: 1'b0,
					done: 1'b0
				};
				tail_q <= tail_q + rob_ndx_t'(1);
			end

			// the issued bit turns on the edge after the grant appears
			// and the selector masks the entry until then
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (grants[p].v) begin
					rob_q[grants[p].ndx].issued <= 1'b1;
				end
			end

			// a unit only completes what it was given, so the entry is
			// already marked issued by the time this arrives
			if (complete_i.v) begin
				rob_q[complete_i.ndx].done <= 1'b1;
			end
		end
	end

	// ========================================
	// outputs
	// ========================================

	// the selector sees the whole array and works out the window itself
	assign rob_entries_o = rob_q;
	assign head_o = head_q;

endmodule

// File: verilog/issue_select.sv
// issue selector picking the oldest ready entries for two ALU ports and one flow-control port
`timescale 1ns/100ps

module issue_select (
	input logic clk,
	input logic rst,
	input sched_pkg::rob_entry_t [sched_pkg::ROB_ENTRIES-1:0] rob_entries_i,
	input sched_pkg::rob_ndx_t head_i,
	input sched_pkg::complete_t complete_i,
	output sched_pkg::issue_t alu0_issue_o,
	output sched_pkg::issue_t alu1_issue_o,
	output sched_pkg::issue_t fcu_issue_o
);

	import sched_pkg::*;

	// ========================================
	// state and scan variables
	// ========================================

	// free slots per port indexed by port_e
	credit_t [NUM_PORTS-1:0] credit_q;
	// grants made one and two cycles ago
	rob_bitmask_t recent_q;
	rob_bitmask_t recent2_q;
	// flow-control grants in the same two cycles
	logic [1:0] fc_hist_q;

	// grants chosen this cycle that the registers carry onto the outputs
	issue_t alu0_nxt;
	issue_t alu1_nxt;
	issue_t fcu_nxt;
	rob_bitmask_t grant_mask;
	rob_bitmask_t blocked;

	// per port credit taken by a grant and returned by a completion
	logic [NUM_PORTS-1:0] take;
	logic [NUM_PORTS-1:0] ret;

	logic alu0_ok;
	logic alu1_ok;
	logic fcu_ok;
	logic fcu_busy;

	// scan temporaries
	rob_ndx_t scan_ndx;
	rob_entry_t scan_e;
	logic scan_ok;
	logic taken0;
	logic fc_older_open;

	// an entry stays blocked until the window shows its issued bit
	assign blocked = recent_q | recent2_q;

	// the FC unit runs one operation at a time even with spare credits
	assign fcu_busy = credit_q[FCU] != credit_t'(UNIT_CREDITS);

	assign alu0_ok = credit_q[ALU0] != '0;
	assign alu1_ok = credit_q[ALU1] != '0;
	assign fcu_ok = !fcu_busy && !(|fc_hist_q);

	// ========================================
	// oldest-first selection
	// ========================================

	// walk from the head so the first match on each port is the oldest
	always_comb begin
		alu0_nxt = '0;
		alu1_nxt = '0;
		fcu_nxt = '0;
		fc_older_open = 1'b0;
		scan_ndx = head_i;
		scan_e = '0;
		scan_ok = 1'b0;
		taken0 = 1'b0;
		for (int i = 0; i < WINDOW_SIZE; i++) begin
			// the index wraps around the end of the array
			scan_ndx = head_i + rob_ndx_t'(i);
			scan_e = rob_entries_i[scan_ndx];
			scan_ok = scan_e.v && !scan_e.issued && !blocked[scan_ndx];
			taken0 = 1'b0;

			// ALU0 accepts both ALU classes
			if (!alu0_nxt.v && alu0_ok && scan_ok &&
				(scan_e.cls == ALU || scan_e.cls == ALU0_ONLY)) begin
				alu0_nxt = '{v: 1'b1, ndx: scan_ndx, tag: scan_e.tag};
				taken0 = 1'b1;
			end

			// ALU1 takes plain ALU work that ALU0 left behind
			if (!alu1_nxt.v && alu1_ok && scan_ok && !taken0 && scan_e.cls == ALU) begin
				alu1_nxt = '{v: 1'b1, ndx: scan_ndx, tag: scan_e.tag};
			end

			// flow control goes out strictly in program order
			// an older FC that has not finished holds back every younger one
			if (scan_e.v && scan_e.cls == FC) begin
				if (!fcu_nxt.v && fcu_ok && scan_ok && !fc_older_open) begin
					fcu_nxt = '{v: 1'b1, ndx: scan_ndx, tag: scan_e.tag};
				end
				if (!scan_e.done) begin
					fc_older_open = 1'b1;
				end
			end
		end
	end

	// one bit per granted entry, fed into the recently issued mask
	always_comb begin
		grant_mask = '0;
		if (alu0_nxt.v) begin
			grant_mask[alu0_nxt.ndx] = 1'b1;
		end
		if (alu1_nxt.v) begin
			grant_mask[alu1_nxt.ndx] = 1'b1;
		end
		if (fcu_nxt.v) begin
			grant_mask[fcu_nxt.ndx] = 1'b1;
		end
	end

	// ========================================
	// credits
	// ========================================

	assign take = {fcu_nxt.v, alu1_nxt.v, alu0_nxt.v};

	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			ret[p] = complete_i.v && (complete_i.port == port_e'(p));
		end
	end

	// ========================================
	// registered grants and history
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			alu0_issue_o <= '0;
			alu1_issue_o <= '0;
			fcu_issue_o <= '0;
			recent_q <= '0;
			recent2_q <= '0;
			fc_hist_q <= '0;
			for (int p = 0; p < NUM_PORTS; p++) begin
				credit_q[p] <= credit_t'(UNIT_CREDITS);
			end
		end else begin
			// each valid lasts exactly one cycle since a new grant
			// is picked every cycle
			alu0_issue_o <= alu0_nxt;
			alu1_issue_o <= alu1_nxt;
			fcu_issue_o <= fcu_nxt;
			recent_q <= grant_mask;
			recent2_q <= recent_q;
			fc_hist_q <= {fc_hist_q[0], fcu_nxt.v};
			// a grant and a completion on the same port cancel out
			for (int p = 0; p < NUM_PORTS; p++) begin
				credit_q[p] <= credit_q[p] - credit_t'(take[p]) + credit_t'(ret[p]);
			end
		end
	end

endmodule

// File: verilog/sched_top.sv
// issue scheduler top level joining the reorder window and the issue selector
`timescale 1ns/100ps

module sched_top (
	input logic clk,
	input logic rst,
	input sched_pkg::dispatch_t dispatch_i,
	input sched_pkg::complete_t complete_i,
	output sched_pkg::issue_t alu0_issue_o,
	output sched_pkg::issue_t alu1_issue_o,
	output sched_pkg::issue_t fcu_issue_o,
	output sched_pkg::retire_t retire_o,
	output logic dispatch_credit_o
);

	import sched_pkg::*;

	// ========================================
	// internal nets
	// ========================================

	// window contents seen by the selector
	rob_entry_t [ROB_ENTRIES-1:0] rob_entries;
	rob_ndx_t head;

	// grants go out of the core and back into the window
	issue_t alu0_issue;
	issue_t alu1_issue;
	issue_t fcu_issue;

	assign alu0_issue_o = alu0_issue;
	assign alu1_issue_o = alu1_issue;
	assign fcu_issue_o = fcu_issue;

	// ========================================
	// instances
	// ========================================

	// the window stores entries and retires them in program order
	rob_window u_rob_window (
		.clk(clk),
		.rst(rst),
		.dispatch_i(dispatch_i),
		.alu0_issue_i(alu0_issue),
		.alu1_issue_i(alu1_issue),
		.fcu_issue_i(fcu_issue),
		.complete_i(complete_i),
		.rob_entries_o(rob_entries),
		.head_o(head),
		.retire_o(retire_o),
		.dispatch_credit_o(dispatch_credit_o)
	);

	// completions also feed the selector so port credits come back
	issue_select u_issue_select (
		.clk(clk),
		.rst(rst),
		.rob_entries_i(rob_entries),
		.head_i(head),
		.complete_i(complete_i),
		.alu0_issue_o(alu0_issue),
		.alu1_issue_o(alu1_issue),
		.fcu_issue_o(fcu_issue)
	);

endmodule

// File: verification/sched_assertions.sv
// bound checker for the grant and credit rules of the issue selector
`timescale 1ns/100ps

module sched_assertions (
	input logic clk,
	input logic rst,
	input sched_pkg::rob_entry_t [sched_pkg::ROB_ENTRIES-1:0] rob_entries_i,
	input sched_pkg::issue_t alu0_issue_i,
	input sched_pkg::issue_t alu1_issue_i,
	input sched_pkg::issue_t fcu_issue_i,
	input sched_pkg::complete_t complete_i
);

	import sched_pkg::*;

	// FC operations seen on the grant bus and not yet back on the completion bus
	logic [1:0] fc_open_q;
	logic fc_done;

	assign fc_done = complete_i.v && complete_i.port == FCU;

	always_ff @(posedge clk) begin
		if (rst) begin
			fc_open_q <= '0;
		end else begin
			fc_open_q <= fc_open_q + 2'(fcu_issue_i.v) - 2'(fc_done);
		end
	end

	// ========================================
	// grant rules
	// ========================================

	// grants of one cycle never point at the same entry
	a_alu_pair: assert property (@(posedge clk) disable iff (rst)
		alu0_issue_i.v && alu1_issue_i.v |-> alu0_issue_i.ndx != alu1_issue_i.ndx)
		else $error("ALU0 and ALU1 granted the same entry");
	a_alu0_fcu: assert property (@(posedge clk) disable iff (rst)
		alu0_issue_i.v && fcu_issue_i.v |-> alu0_issue_i.ndx != fcu_issue_i.ndx)
		else $error("ALU0 and FCU granted the same entry");
	a_alu1_fcu: assert property (@(posedge clk) disable iff (rst)
		alu1_issue_i.v && fcu_issue_i.v |-> alu1_issue_i.ndx != fcu_issue_i.ndx)
		else $error("ALU1 and FCU granted the same entry");

	// the grant in view is not counted yet, so every earlier FC must be complete
	a_fcu_idle: assert property (@(posedge clk) disable iff (rst)
		fcu_issue_i.v |-> fc_open_q == '0)
		else $error("FCU granted while an FC operation was in flight");

	// the entry is still in the window, unissued, while its grant is visible
	a_alu1_class: assert property (@(posedge clk) disable iff (rst)
		alu1_issue_i.v |-> rob_entries_i[alu1_issue_i.ndx].cls != ALU0_ONLY)
		else $error("ALU1 carried an ALU0_ONLY operation");

endmodule

bind issue_select sched_assertions u_sched_assertions (
	.clk(clk),
	.rst(rst),
	.rob_entries_i(rob_entries_i),
	.alu0_issue_i(alu0_issue_o),
	.alu1_issue_i(alu1_issue_o),
	.fcu_issue_i(fcu_issue_o),
	.complete_i(complete_i)
);

// File: verification/sched_tb.sv
// testbench for the issue scheduler with a random dispatcher, unit models and a reference model
`timescale 1ns/100ps

module sched_tb;

	import sched_pkg::*;

	// ========================================
	// run constants and types
	// ========================================

	localparam int NUM_OPS = 400;
	// a generous bound of twelve cycles per operation
	localparam int CYCLE_LIMIT = NUM_OPS * 12;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_DELAY = 6;

	// life of one tag as the model sees it
	typedef enum logic [2:0] {ST_FREE, ST_WAIT, ST_ISSUED, ST_DONE, ST_RETIRED} tag_state_e;

	// an operation held by a unit model until its completion is due
	typedef struct packed {
		port_e port;
		rob_ndx_t ndx;
		tag_t tag;
		logic [31:0] due;
	} unit_op_t;

	logic clk;
	logic rst;
	dispatch_t dispatch_i;
	complete_t complete_i;
	issue_t alu0_issue;
	issue_t alu1_issue;
	issue_t fcu_issue;
	retire_t retire;
	logic dispatch_credit;

	int seed;
	int cycle;
	int value_errors;
	int other_errors;
	// dispatcher entry credits that the credit pulse returns
	int credits;
	int sent;
	int retired;
	// flow-control operations issued and not yet completed
	int fc_open;
	int inflight [NUM_PORTS];
	// the slot the window will use for the next dispatch
	rob_ndx_t tail_ndx;
	tag_state_e tag_state [2**TAG_W];
	op_class_e tag_cls [2**TAG_W];
	rob_ndx_t tag_ndx [2**TAG_W];
	// program order of all live tags and of the FC tags still to issue
	tag_t disp_q [$];
	tag_t fc_wait_q [$];
	unit_op_t pend_q [$];

	sched_top uut (
		.clk(clk),
		.rst(rst),
		.dispatch_i(dispatch_i),
		.complete_i(complete_i),
		.alu0_issue_o(alu0_issue),
		.alu1_issue_o(alu1_issue),
		.fcu_issue_o(fcu_issue),
		.retire_o(retire),
		.dispatch_credit_o(dispatch_credit)
	);

	always #2 clk = ~clk;

	// ========================================
	// checking helpers
	// ========================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("error at cycle %0d: %s", cycle, msg);
		other_errors++;
	endtask

	task automatic check_idle(input string when);
		check_value({when, " alu0_issue_o.v"}, 32'(alu0_issue.v), 32'd0);
		check_value({when, " alu1_issue_o.v"}, 32'(alu1_issue.v), 32'd0);
		check_value({when, " fcu_issue_o.v"}, 32'(fcu_issue.v), 32'd0);
		check_value({when, " retire_o.v"}, 32'(retire.v), 32'd0);
		check_value({when, " dispatch_credit_o"}, 32'(dispatch_credit), 32'd0);
	endtask

	// one grant seen on a port is checked and handed to that unit model
	task automatic observe_issue(input port_e port, input issue_t iss);
		tag_t t;
		logic allowed;
		int delay;
		if (iss.v) begin
			t = iss.tag;
			if (tag_state[t] != ST_WAIT) begin
				report_error($sformatf("tag %0d issued on %s while not waiting", t, port.name()));
			end
			check_value("issue ndx", 32'(iss.ndx), 32'(tag_ndx[t]));
			// plain ALU work may use either ALU while the other classes have one port
			case (tag_cls[t])
				ALU: allowed = (port != FCU);
				ALU0_ONLY: allowed = (port == ALU0);
				default: allowed = (port == FCU);
			endcase
			if (!allowed) begin
				report_error($sformatf("tag %0d of class %s issued on %s", t,
					tag_cls[t].name(), port.name()));
			end
			if (port == FCU) begin
				if (fc_wait_q.size() == 0) begin
					report_error("flow-control issue with no FC operation waiting");
				end else begin
					check_value("fcu_issue_o.tag", 32'(t), 32'(fc_wait_q[0]));
					void'(fc_wait_q.pop_front());
				end
				if (fc_open != 0) begin
					report_error("flow-control issue while an older FC is incomplete");
				end
				fc_open++;
			end
			tag_state[t] = ST_ISSUED;
			inflight[int'(port)]++;
			if (inflight[int'(port)] > UNIT_CREDITS) begin
				report_error($sformatf("%s has %0d operations in flight", port.name(),
					inflight[int'(port)]));
			end
			delay = 1 + int'($unsigned($random(seed)) % MAX_DELAY);
			pend_q.push_back('{port: port, ndx: iss.ndx, tag: t, due: 32'(cycle + delay)});
		end
	endtask

	task automatic observe_outputs;
		tag_t exp_tag;
		observe_issue(ALU0, alu0_issue);
		observe_issue(ALU1, alu1_issue);
		observe_issue(FCU, fcu_issue);
		// a retire and its credit leave on the same edge
		check_value("dispatch_credit_o", 32'(dispatch_credit), 32'(retire.v));
		if (dispatch_credit) begin
			credits++;
		end
		if (retire.v) begin
			if (disp_q.size() == 0) begin
				report_error("retire with no operation outstanding");
			end else begin
				exp_tag = disp_q.pop_front();
				check_value("retire_o.tag", 32'(retire.tag), 32'(exp_tag));
				if (tag_state[retire.tag] != ST_DONE) begin
					report_error($sformatf("tag %0d retired before completion", retire.tag));
				end
				tag_state[retire.tag] = ST_RETIRED;
				retired++;
			end
		end
	endtask

	// ========================================
	// stimulus
	// ========================================

	task automatic drive_dispatch;
		int r;
		op_class_e new_cls;
		tag_t t;
		dispatch_i = '0;
		// the dispatcher pauses now and then even with credits in hand
		if (credits > 0 && sent < NUM_OPS && ($random(seed) & 3) != 0) begin
			r = int'($unsigned($random(seed)) % 10);
			if (r < 6) begin
				new_cls = ALU;
			end else if (r < 8) begin
				new_cls = ALU0_ONLY;
			end else begin
				new_cls = FC;
			end
			t = tag_t'(sent);
			// tags wrap, so any earlier user of this tag must be gone
			if (tag_state[t] != ST_FREE && tag_state[t] != ST_RETIRED) begin
				report_error($sformatf("tag %0d reused while still live", t));
			end
			dispatch_i = '{v: 1'b1, cls: new_cls, tag: t};
			tag_state[t] = ST_WAIT;
			tag_cls[t] = new_cls;
			tag_ndx[t] = tail_ndx;
			tail_ndx = tail_ndx + rob_ndx_t'(1);
			disp_q.push_back(t);
			if (new_cls == FC) begin
				fc_wait_q.push_back(t);
			end
			credits--;
			sent++;
		end
	endtask

	// index of the oldest operation a unit holds and -1 when it holds none
	function automatic int first_pending(input port_e port);
		int found;
		found = -1;
		for (int i = 0; i < pend_q.size(); i++) begin
			if (found < 0 && pend_q[i].port == port) begin
				found = i;
			end
		end
		return found;
	endfunction

	task automatic drive_completion;
		int start;
		int p;
		int i;
		logic done_one;
		complete_i = '0;
		done_one = 1'b0;
		// a random first port keeps one unit from always winning the bus
		start = int'($unsigned($random(seed)) % NUM_PORTS);
		for (int k = 0; k < NUM_PORTS; k++) begin
			p = (start + k) % NUM_PORTS;
			i = first_pending(port_e'(p));
			if (!done_one && i >= 0 && pend_q[i].due <= 32'(cycle)) begin
				complete_i = '{v: 1'b1, port: pend_q[i].port, ndx: pend_q[i].ndx};
				tag_state[pend_q[i].tag] = ST_DONE;
				inflight[p]--;
				if (pend_q[i].port == FCU) begin
					fc_open--;
				end
				pend_q.delete(i);
				done_one = 1'b1;
			end
		end
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		seed = 32'h8feee3b7;
		clk = 1'b0;
		rst = 1'b1;
		dispatch_i = '0;
		complete_i = '0;
		cycle = 0;
		value_errors = 0;
		other_errors = 0;
		credits = ROB_ENTRIES;
		sent = 0;
		retired = 0;
		fc_open = 0;
		tail_ndx = '0;
		for (int i = 0; i < 2**TAG_W; i++) begin
			tag_state[i] = ST_FREE;
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			inflight[p] = 0;
		end
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_idle("reset");
		end
		rst = 1'b0;
		@(negedge clk);
		check_idle("first cycle after reset");
		// inputs change on the falling edge and the results of the rising edge
		// are read half a cycle later
		while (retired < NUM_OPS && cycle < CYCLE_LIMIT) begin
			drive_dispatch;
			drive_completion;
			@(negedge clk);
			cycle++;
			observe_outputs;
		end
		dispatch_i = '0;
		complete_i = '0;
		if (retired < NUM_OPS) begin
			report_error($sformatf("timeout after %0d cycles with %0d of %0d operations retired",
				cycle, retired, NUM_OPS));
		end
		check_value("retired operations", 32'(retired), 32'(NUM_OPS));
		check_value("dispatcher credits", 32'(credits), 32'(ROB_ENTRIES));
		check_value("operations left in units", 32'(pend_q.size()), 32'd0);
		for (int p = 0; p < NUM_PORTS; p++) begin
			check_value("operations in flight", 32'(inflight[p]), 32'd0);
		end
		$display("closing report: %0d value errors, %0d other errors", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: sched.f
verilog/sched_pkg.sv
verilog/rob_window.sv
verilog/issue_select.sv
verilog/sched_top.sv
verification/sched_assertions.sv
verification/sched_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the scheduler testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module sched_tb \
	-f sched.f \
	-o sched_sim

./obj_dir/sched_sim | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation finished without failures"
